//--- rtl/pu_div_pkg.sv
package pu_div_pkg;

    // --------------------------------------------------
    // widths and layout
    // --------------------------------------------------
    localparam int DATA_WIDTH  = 32;
    localparam int ATTR_WIDTH  = 4;
    localparam int INVALID_BIT = 0;   // invalid flag position in attr
    localparam int PIPELINE    = 4;   // divider latency in cycles

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ATTR_WIDTH-1:0] attr_t;

    // --------------------------------------------------
    // bus side
    // --------------------------------------------------

    // one command per cycle, no handshake
    typedef struct packed {
        logic  sel;   // 0 denom / quotient, 1 numer / remainder
        logic  wr;
        logic  oe;
        data_t data;
        attr_t attr;
    } pu_cmd_t;

    typedef struct packed {
        data_t data;
        attr_t attr;
    } pu_resp_t;

    // --------------------------------------------------
    // divider output
    // --------------------------------------------------
    typedef struct packed {
        data_t quotient;
        data_t remainder;   // sign follows numerator
    } div_result_t;

endpackage

//--- rtl/div_pipeline.sv
`timescale 1ns/1ps

module div_pipeline (
    input  logic                    clk,
    input  logic                    rst,
    input  pu_div_pkg::data_t       numer,
    input  pu_div_pkg::data_t       denom,
    output pu_div_pkg::div_result_t result
);

    // state carried from stage to stage
    typedef struct packed {
        pu_div_pkg::data_t rem;       // partial remainder
        pu_div_pkg::data_t num;       // numerator bits left, msb first
        pu_div_pkg::data_t quo;       // quotient bits so far
        pu_div_pkg::data_t den;       // denominator magnitude
        logic              neg_quo;
        logic              neg_rem;
    } stage_t;

    stage_t front;
    stage_t stage_d [pu_div_pkg::PIPELINE];
    stage_t stage_q [pu_div_pkg::PIPELINE];
    stage_t last;

    // --------------------------------------------------
    // restoring step, DATA_WIDTH/PIPELINE bits per call
    // --------------------------------------------------
    function automatic stage_t div_step(input stage_t s_in);
        stage_t s;
        s = s_in;
        for (int i = 0; i < pu_div_pkg::DATA_WIDTH / pu_div_pkg::PIPELINE; i++) begin
            // bring down next numerator bit
            s.rem = {s.rem[pu_div_pkg::DATA_WIDTH-2:0], s.num[pu_div_pkg::DATA_WIDTH-1]};
            s.num = s.num << 1;
            s.quo = s.quo << 1;
            if (s.rem >= s.den) begin
                s.rem    = s.rem - s.den;
                s.quo[0] = 1'b1;
            end
        end
        return s;
    endfunction

    // --------------------------------------------------
    // front end: magnitudes and result signs
    // --------------------------------------------------
    always_comb begin
        front         = '0;
        front.num     = numer[pu_div_pkg::DATA_WIDTH-1] ? -numer : numer;
        front.den     = denom[pu_div_pkg::DATA_WIDTH-1] ? -denom : denom;
        // truncation toward zero, so signs applied to magnitudes at the end
        front.neg_quo = numer[pu_div_pkg::DATA_WIDTH-1] ^ denom[pu_div_pkg::DATA_WIDTH-1];
        front.neg_rem = numer[pu_div_pkg::DATA_WIDTH-1];
    end

    // --------------------------------------------------
    // stages
    // --------------------------------------------------
    always_comb begin
        stage_d[0] = div_step(front);
        for (int k = 1; k < pu_div_pkg::PIPELINE; k++) begin
            stage_d[k] = div_step(stage_q[k-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < pu_div_pkg::PIPELINE; k++) begin
                stage_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < pu_div_pkg::PIPELINE; k++) begin
                stage_q[k] <= stage_d[k];   // new pair every cycle
            end
        end
    end

    // --------------------------------------------------
    // sign fixup on last stage
    // --------------------------------------------------
    assign last = stage_q[pu_div_pkg::PIPELINE-1];

    always_comb begin
        result.quotient  = last.neg_quo ? -last.quo : last.quo;
        result.remainder = last.neg_rem ? -last.rem : last.rem;
    end

endmodule

//--- rtl/div_validity.sv
`timescale 1ns/1ps

module div_validity (
    input  logic              clk,
    input  logic              rst,
    input  logic              numer_invalid,
    input  logic              denom_invalid,
    input  pu_div_pkg::data_t denom,
    output logic              invalid
);

    // bits DATA_WIDTH-1 down to DATA_WIDTH/2-1
    logic [pu_div_pkg::DATA_WIDTH/2:0] denom_top;
    logic                              denom_zero;
    logic                              denom_out_of_range;
    logic                              attr_invalid;
    logic                              flag_now;
    logic [pu_div_pkg::PIPELINE-1:0]   flag_sr;

    // --------------------------------------------------
    // checks on latched operands
    // --------------------------------------------------
    assign denom_top  = denom[pu_div_pkg::DATA_WIDTH-1:pu_div_pkg::DATA_WIDTH/2-1];
    assign denom_zero = (denom == '0);

    // fits half-width signed only if sign extension bits all agree
    assign denom_out_of_range = !((&denom_top) || !(|denom_top));

    assign attr_invalid = numer_invalid | denom_invalid;
    assign flag_now     = attr_invalid | denom_zero | denom_out_of_range;

    // --------------------------------------------------
    // delay line, same depth as divider
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_sr <= '0;
        end else begin
            flag_sr <= {flag_sr[pu_div_pkg::PIPELINE-2:0], flag_now};
        end
    end

    assign invalid = flag_sr[pu_div_pkg::PIPELINE-1];   // aligned with result

endmodule

//--- rtl/pu_div.sv
`timescale 1ns/1ps

module pu_div #(
    parameter int SCALING_POWER = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  pu_div_pkg::pu_cmd_t  cmd,
    output pu_div_pkg::pu_resp_t resp
);

    // bus strobes
    logic wr_strobe;      // operand write
    logic start_strobe;   // latch operands, start division
    logic rd_strobe;

    // operand registers
    pu_div_pkg::data_t denom_q;
    pu_div_pkg::data_t numer_q;
    pu_div_pkg::attr_t denom_attr_q;
    pu_div_pkg::attr_t numer_attr_q;

    // compute latch
    pu_div_pkg::data_t denom_lat;
    pu_div_pkg::data_t numer_lat;
    logic              denom_inv_lat;
    logic              numer_inv_lat;

    pu_div_pkg::div_result_t result;
    logic                    invalid;

    // --------------------------------------------------
    // strobe decode
    // --------------------------------------------------
    assign wr_strobe    = cmd.wr & ~cmd.oe;
    assign start_strobe = cmd.wr & cmd.oe;
    assign rd_strobe    = ~cmd.wr & cmd.oe;

    // --------------------------------------------------
    // operand registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            denom_q      <= '0;
            denom_attr_q <= '0;
            numer_q      <= '0;
            numer_attr_q <= '0;
        end else if (wr_strobe) begin
            if (cmd.sel) begin
                numer_q      <= cmd.data;
                numer_attr_q <= cmd.attr;
            end else begin
                denom_q      <= cmd.data;
                denom_attr_q <= cmd.attr;
            end
        end
    end

    // --------------------------------------------------
    // compute latch, feeds both parts
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            denom_lat     <= '0;
            numer_lat     <= '0;
            denom_inv_lat <= 1'b0;
            numer_inv_lat <= 1'b0;
        end else if (start_strobe) begin
            denom_lat     <= denom_q;
            numer_lat     <= numer_q;
            denom_inv_lat <= denom_attr_q[pu_div_pkg::INVALID_BIT];
            numer_inv_lat <= numer_attr_q[pu_div_pkg::INVALID_BIT];
        end
    end

    div_pipeline u_div_pipeline (
        .clk    (clk),
        .rst    (rst),
        .numer  (numer_lat),
        .denom  (denom_lat),
        .result (result)
    );

    div_validity u_div_validity (
        .clk           (clk),
        .rst           (rst),
        .numer_invalid (numer_inv_lat),
        .denom_invalid (denom_inv_lat),
        .denom         (denom_lat),
        .invalid       (invalid)
    );

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        resp = '0;   // non-read cycles show nothing
        if (rd_strobe) begin
            if (cmd.sel) begin
                resp.data = result.remainder;
            end else begin
                resp.data = result.quotient << SCALING_POWER;
            end
            resp.attr[pu_div_pkg::INVALID_BIT] = invalid;   // other attr bits stay 0
        end
    end

endmodule

//--- verification/pu_div_properties.sv
`timescale 1ns/1ps

module pu_div_properties (
    input logic                 clk,
    input logic                 rst,
    input pu_div_pkg::pu_cmd_t  cmd,
    input pu_div_pkg::pu_resp_t resp
);

    logic read_cycle;

    assign read_cycle = cmd.oe & ~cmd.wr;

    // --------------------------------------------------
    // response shape
    // --------------------------------------------------

    // only the invalid flag is ever driven
    attr_upper_zero: assert property (
        @(posedge clk) resp.attr[pu_div_pkg::ATTR_WIDTH-1:1] == '0
    ) else $error("resp.attr upper bits set: %h", resp.attr);

    quiet_when_not_read: assert property (
        @(posedge clk) !read_cycle |-> resp == '0
    ) else $error("resp not zero outside a read: %h", resp);

    // --------------------------------------------------
    // reset
    // --------------------------------------------------

    // divider and flag line cleared, so even a read shows zero
    zero_after_reset: assert property (
        @(posedge clk) rst |=> resp == '0
    ) else $error("resp not zero after reset: %h", resp);

endmodule

bind pu_div pu_div_properties u_properties (
    .clk  (clk),
    .rst  (rst),
    .cmd  (cmd),
    .resp (resp)
);

//--- verification/pu_div_tb.sv
`timescale 1ns/1ps

module pu_div_tb;

    localparam int SCALE         = 1;    // SCALING_POWER of the DUT
    localparam int WORDS_PER_VEC = 8;
    localparam int MAX_VECS      = 64;
    localparam int WAIT_LIMIT    = 40;   // idle slots allowed per wait

    // vector kinds, first column of the data file
    localparam logic [31:0] KIND_FULL    = 32'd0;
    localparam logic [31:0] KIND_FLAG    = 32'd1;   // invalid flag only
    localparam logic [31:0] KIND_ISOLATE = 32'd2;
    localparam logic [31:0] KIND_PAIR    = 32'd3;   // overlapped with next line
    localparam logic [31:0] END_MARK     = 32'hffff_ffff;

    logic                 clk;
    logic                 rst;
    pu_div_pkg::pu_cmd_t  cmd;
    pu_div_pkg::pu_resp_t resp;

    logic [31:0] vec_mem [0:MAX_VECS*WORDS_PER_VEC-1];
    logic [31:0] lfsr_state = 32'h92f;
    int          slot = 0;          // index of the current bus cycle
    int          n_vecs = 0;
    int          data_errors = 0;
    int          flag_errors = 0;
    int          bus_errors = 0;
    int          vector_errors = 0;
    int          timeouts = 0;
    bit          timed_out = 1'b0;

    pu_div #(.SCALING_POWER(SCALE)) uut (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .resp (resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] vec_field(input int v, input int col);
        return vec_mem[v * WORDS_PER_VEC + col];
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    task automatic random_word(input int nbits, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // numer = quo * denom + rem with |rem| < |denom| and rem sign of numer
    function automatic bit vector_consistent(input int v);
        logic [31:0] n;
        logic [31:0] d;
        logic [31:0] q;
        logic [31:0] rm;
        logic [31:0] abs_d;
        logic [31:0] abs_r;
        n     = vec_field(v, 1);
        d     = vec_field(v, 3);
        q     = vec_field(v, 5);
        rm    = vec_field(v, 6);
        abs_d = d[31] ? -d : d;
        abs_r = rm[31] ? -rm : rm;
        if (q * d + rm != n) return 1'b0;
        if (rm != 0 && rm[31] != n[31]) return 1'b0;
        return abs_r < abs_d;
    endfunction

    // drive after the edge and sample mid-cycle
    task automatic bus_cycle(input pu_div_pkg::pu_cmd_t c, output pu_div_pkg::pu_resp_t r);
        @(posedge clk);
        #1;
        cmd  = c;
        slot = slot + 1;
        @(negedge clk);
        r = resp;
        if (!(c.oe && !c.wr) && resp != '0) begin
            bus_errors++;
            $display("error resp in non-read slot %0d: got %h expected 0", slot, resp);
        end
    endtask

    task automatic idle_cycle();
        pu_div_pkg::pu_cmd_t  c;
        pu_div_pkg::pu_resp_t r;
        c = '0;
        bus_cycle(c, r);
    endtask

    task automatic random_cycle(input bit wr, input bit oe);
        pu_div_pkg::pu_cmd_t  c;
        pu_div_pkg::pu_resp_t r;
        logic [31:0]          w;
        c    = '0;
        c.wr = wr;
        c.oe = oe;
        random_word(1, w);
        c.sel = w[0];
        random_word(32, w);
        c.data = w;
        random_word(pu_div_pkg::ATTR_WIDTH, w);
        c.attr = w[pu_div_pkg::ATTR_WIDTH-1:0];
        bus_cycle(c, r);
    endtask

    task automatic write_operand(input bit sel, input logic [31:0] data, input logic [31:0] attr);
        pu_div_pkg::pu_cmd_t  c;
        pu_div_pkg::pu_resp_t r;
        c      = '0;
        c.sel  = sel;
        c.wr   = 1'b1;
        c.data = data;
        c.attr = attr[pu_div_pkg::ATTR_WIDTH-1:0];
        bus_cycle(c, r);
    endtask

    task automatic load_operands(input int v);
        write_operand(1'b0, vec_field(v, 3), vec_field(v, 4));   // denominator
        write_operand(1'b1, vec_field(v, 1), vec_field(v, 2));   // numerator
    endtask

    task automatic start_division(output int start_slot);
        pu_div_pkg::pu_cmd_t  c;
        pu_div_pkg::pu_resp_t r;
        c    = '0;
        c.wr = 1'b1;
        c.oe = 1'b1;
        bus_cycle(c, r);
        start_slot = slot;
    endtask

    // idle until the next slot is the target one
    task automatic wait_for_slot(input int target);
        int guard;
        guard = 0;
        while (slot + 1 < target && !timed_out) begin
            idle_cycle();
            guard++;
            if (guard > WAIT_LIMIT) begin
                timed_out = 1'b1;
                timeouts++;
                $display("timeout while waiting for slot %0d, stuck at slot %0d", target, slot);
            end
        end
    endtask

    task automatic read_and_check(input int v, input bit sel);
        pu_div_pkg::pu_cmd_t  c;
        pu_div_pkg::pu_resp_t r;
        pu_div_pkg::data_t    exp_data;
        pu_div_pkg::attr_t    exp_attr;
        if (timed_out) return;
        c     = '0;
        c.oe  = 1'b1;
        c.sel = sel;
        bus_cycle(c, r);
        exp_data = sel ? vec_field(v, 6) : vec_field(v, 5) << SCALE;
        exp_attr = '0;
        exp_attr[pu_div_pkg::INVALID_BIT] = (vec_field(v, 7) != 0);
        if (vec_field(v, 0) != KIND_FLAG && r.data != exp_data) begin
            data_errors++;
            $display("error vec %0d resp.data (%s): got %h expected %h",
                     v, sel ? "remainder" : "quotient", r.data, exp_data);
        end
        if (r.attr != exp_attr) begin
            flag_errors++;
            $display("error vec %0d resp.attr: got %h expected %h", v, r.attr, exp_attr);
        end
    endtask

    // --------------------------------------------------
    // vector procedures
    // --------------------------------------------------
    task automatic run_single(input int v);
        int start_slot;
        load_operands(v);
        if (vec_field(v, 0) == KIND_ISOLATE) begin
            random_cycle(1'b0, 1'b0);
            random_cycle(1'b1, 1'b1);   // bus data ignored on a start
            random_cycle(1'b1, 1'b1);
        end
        start_division(start_slot);
        wait_for_slot(start_slot + 1 + pu_div_pkg::PIPELINE);
        read_and_check(v, 1'b0);
        read_and_check(v, 1'b1);
    endtask

    // second pair written and started while the first is in flight
    task automatic run_pair(input int v);
        int first_slot;
        int second_slot;
        load_operands(v);
        start_division(first_slot);
        load_operands(v + 1);
        start_division(second_slot);
        wait_for_slot(first_slot + 1 + pu_div_pkg::PIPELINE);
        read_and_check(v, 1'b0);
        read_and_check(v, 1'b1);
        wait_for_slot(second_slot + 1 + pu_div_pkg::PIPELINE);
        read_and_check(v + 1, 1'b0);
        read_and_check(v + 1, 1'b1);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int v;
        cmd = '0;
        rst = 1'b1;
        for (int i = 0; i < MAX_VECS * WORDS_PER_VEC; i++) begin
            vec_mem[i] = END_MARK;
        end
        $readmemh("verification/pu_div_testdata.txt", vec_mem);
        while (n_vecs < MAX_VECS && vec_field(n_vecs, 0) != END_MARK) begin
            if (vec_field(n_vecs, 0) != KIND_FLAG && !vector_consistent(n_vecs)) begin
                vector_errors++;
                $display("test vector %0d does not follow the division rules", n_vecs);
            end
            n_vecs++;
        end
        if (n_vecs == 0) begin
            $display("no test vectors were read");
        end

        repeat (3) @(posedge clk);
        #1;
        rst    = 1'b0;
        cmd.oe = 1'b1;   // read straight out of reset
        @(negedge clk);
        if (resp != '0) begin
            bus_errors++;
            $display("error resp read after reset: got %h expected 0", resp);
        end

        v = 0;
        while (v < n_vecs && !timed_out) begin
            case (vec_field(v, 0))
                KIND_FULL, KIND_FLAG, KIND_ISOLATE: begin
                    run_single(v);
                    v++;
                end
                KIND_PAIR: begin
                    run_pair(v);
                    v += 2;
                end
                default: begin
                    vector_errors++;
                    $display("test vector %0d has an unknown kind", v);
                    v++;
                end
            endcase
        end

        $display("errors: data %0d, flag %0d, bus %0d, vector %0d, timeout %0d, vectors %0d",
                 data_errors, flag_errors, bus_errors, vector_errors, timeouts, n_vecs);
        if (data_errors + flag_errors + bus_errors + vector_errors + timeouts == 0
                && n_vecs > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/pu_div_testdata.txt
// kind numer numer_attr denom denom_attr quotient remainder invalid
// kind 0 full check, 1 flag only, 2 bus isolation, 3 overlapped pair with the next line
// sign pairings and plain values
0 00000064 0 00000007 0 0000000e 00000002 0
0 ffffff9c 0 00000007 0 fffffff2 fffffffe 0
0 00000064 0 fffffff9 0 fffffff2 00000002 0
0 ffffff9c 0 fffffff9 0 0000000e fffffffe 0
0 12345678 0 00001234 0 00010004 00000da8 0
0 00000000 0 00000005 0 00000000 00000000 0
0 00000005 0 00000009 0 00000000 00000005 0
0 7fffffff 0 00007fff 0 00010002 00000001 0
0 80000000 0 ffff8000 0 00010000 00000000 0
0 fffffff9 0 00000002 0 fffffffd ffffffff 0
0 000003e8 0 ffffffff 0 fffffc18 00000000 0
// zero denominator
1 00000064 0 00000000 0 00000000 00000000 1
1 ffffffd6 0 00000000 0 00000000 00000000 1
// denominator outside 16 bit signed range
0 00100000 0 00010000 0 00000010 00000000 1
0 00100000 0 fffe0000 0 fffffff8 00000000 1
0 00010000 0 00008000 0 00000002 00000000 1
0 00000064 0 ffff7fff 0 00000000 00000064 1
// attribute invalid bits
0 00000064 1 00000007 0 0000000e 00000002 1
0 00000064 0 00000007 1 0000000e 00000002 1
0 00000064 e 00000007 6 0000000e 00000002 0
0 ffffff9c 9 fffffff9 3 0000000e fffffffe 1
// bus isolation
2 00000064 0 00000007 0 0000000e 00000002 0
2 ffffff9c 0 00000003 0 ffffffdf ffffffff 0
// overlapped starts
3 00000064 0 00000007 0 0000000e 00000002 0
3 00001000 0 fffffff0 0 ffffff00 00000000 0
3 7fffffff 0 00010000 0 00007fff 0000ffff 1
3 fffffff9 0 00000002 0 fffffffd ffffffff 0

//--- sim.f
rtl/pu_div_pkg.sv
rtl/div_pipeline.sv
rtl/div_validity.sv
rtl/pu_div.sv
verification/pu_div_properties.sv
verification/pu_div_tb.sv

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the pu_div testbench

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -sv -f sim.f --top-module pu_div_tb -Mdir obj_dir \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/Vpu_div_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TB PASSED$" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
